// File: Bender.yml
package:
  name: link_emu

sources:
  - hdl/link_emu_pkg.sv
  - hdl/bit_clk_gen.sv
  - hdl/prbs_gen.sv
  - hdl/tx_driver.sv
  - hdl/chan_model.sv
  - hdl/rx_checker.sv
  - hdl/link_emu_top.sv
  - target: test
    files:
      - verif/link_emu_tb.sv

// File: hdl/bit_clk_gen.sv
`timescale 1ns/1ps

module bit_clk_gen import link_emu_pkg::*; (
    input  logic      emu_clk,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  half_per_t t_hi_i,
    input  half_per_t t_lo_i,
    output logic      bit_stb_o
);

    osc_state_e state_q;
    osc_state_e prev_q;
    half_per_t  cnt_q;
    half_per_t  hi_load;
    half_per_t  lo_load;
    logic       rise;

    // Counter reload where a zero time acts as one cycle
    assign hi_load = (t_hi_i == '0) ? '0 : t_hi_i - 1'b1;
    assign lo_load = (t_lo_i == '0) ? '0 : t_lo_i - 1'b1;

    // LO to HI edge of the modelled clock
    assign rise = (state_q == OSC_HI) && (prev_q == OSC_LO);

    ////////////////////////////////////////
    // Oscillator and edge detector
    ////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= OSC_LO;
            prev_q    <= OSC_LO;
            cnt_q     <= '0;
            bit_stb_o <= 1'b0;
        end else begin
            prev_q    <= state_q;
            bit_stb_o <= en_i && rise;
            if (!en_i) begin
                // Park in the low phase ready for a full low time
                state_q <= OSC_LO;
                cnt_q   <= lo_load;
            end else if (cnt_q == '0) begin
                if (state_q == OSC_LO) begin
                    state_q <= OSC_HI;
                    cnt_q   <= hi_load;
                end else begin
                    state_q <= OSC_LO;
                    cnt_q   <= lo_load;
                end
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

// File: hdl/chan_model.sv
`timescale 1ns/1ps

module chan_model import link_emu_pkg::*; (
    input  logic    emu_clk,
    input  logic    arst_n_i,
    input  logic    bit_stb_i,
    input  sample_t level_i,
    output sample_t sample_o
);

    sample_t x1_q;
    sample_t x2_q;
    ch_acc_t acc;
    ch_acc_t acc_sh;
    sample_t sat;

    ////////////////////////////////////////
    // ISI sum
    ////////////////////////////////////////

    assign acc = ch_acc_t'(CH_C0) * ch_acc_t'(level_i)
               + ch_acc_t'(CH_C1) * ch_acc_t'(x1_q)
               + ch_acc_t'(CH_C2) * ch_acc_t'(x2_q);

    assign acc_sh = acc >>> CH_SHIFT;

    // Clamp to the sample range
    always_comb begin
        if (acc_sh > ch_acc_t'(SAMPLE_MAX)) begin
            sat = sample_t'(SAMPLE_MAX);
        end else if (acc_sh < ch_acc_t'(SAMPLE_MIN)) begin
            sat = sample_t'(SAMPLE_MIN);
        end else begin
            sat = sample_t'(acc_sh);
        end
    end

    // Two-deep level history starting from zero
    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x1_q     <= '0;
            x2_q     <= '0;
            sample_o <= '0;
        end else if (bit_stb_i) begin
            x1_q     <= level_i;
            x2_q     <= x1_q;
            sample_o <= sat;
        end
    end

endmodule

// File: hdl/link_emu_pkg.sv
package link_emu_pkg;

    ////////////////////////////////////////
    // Sample and counter types
    ////////////////////////////////////////

    localparam int SAMPLE_W = 10;
    localparam int CH_ACC_W = 14;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [7:0]                 half_per_t;
    typedef logic [15:0]                err_cnt_t;
    typedef logic [6:0]                 prbs_state_t;

    // Wide enough for the unshifted channel sum
    typedef logic signed [CH_ACC_W-1:0] ch_acc_t;

    localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    ////////////////////////////////////////
    // PRBS7, x^7 + x^6 + 1
    ////////////////////////////////////////

    localparam prbs_state_t PRBS_SEED = 7'd1;
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

    ////////////////////////////////////////
    // Driver and channel
    ////////////////////////////////////////

    // Levels come out as +-80 or +-112
    localparam int DRV_MAIN = 96;
    localparam int DRV_POST = 16;

    // Taps 4/1/1, then divide by 4
    localparam int CH_C0    = 4;
    localparam int CH_C1    = 1;
    localparam int CH_C2    = 1;
    localparam int CH_SHIFT = 2;

    // Checker lock
    localparam int LOCK_LEN = 16;
    typedef logic [$clog2(LOCK_LEN + 1)-1:0] run_cnt_t;

    // Bit clock oscillator phase
    typedef enum logic {
        OSC_LO,
        OSC_HI
    } osc_state_e;

endpackage

// File: hdl/link_emu_top.sv
`timescale 1ns/1ps

module link_emu_top import link_emu_pkg::*; (
    input  logic      emu_clk,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  half_per_t t_hi_i,
    input  half_per_t t_lo_i,
    input  logic      inj_err_i,
    input  logic      clear_i,
    output logic      bit_stb_o,
    output sample_t   sample_o,
    output logic      rx_bit_o,
    output logic      locked_o,
    output err_cnt_t  err_cnt_o
);

    logic    tx_bit;
    sample_t level;

    ////////////////////////////////////////
    // Bit clock
    ////////////////////////////////////////

    bit_clk_gen bit_clk_gen_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .en_i      (en_i),
        .t_hi_i    (t_hi_i),
        .t_lo_i    (t_lo_i),
        .bit_stb_o (bit_stb_o)
    );

    ////////////////////////////////////////
    // Source, medium and result
    ////////////////////////////////////////

    prbs_gen prbs_gen_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .bit_stb_i (bit_stb_o),
        .inj_err_i (inj_err_i),
        .tx_bit_o  (tx_bit)
    );

    tx_driver tx_driver_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .bit_stb_i (bit_stb_o),
        .tx_bit_i  (tx_bit),
        .level_o   (level)
    );

    chan_model chan_model_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .bit_stb_i (bit_stb_o),
        .level_i   (level),
        .sample_o  (sample_o)
    );

    rx_checker rx_checker_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .bit_stb_i (bit_stb_o),
        .clear_i   (clear_i),
        .sample_i  (sample_o),
        .rx_bit_o  (rx_bit_o),
        .locked_o  (locked_o),
        .err_cnt_o (err_cnt_o)
    );

endmodule

// File: hdl/prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen import link_emu_pkg::*; (
    input  logic emu_clk,
    input  logic arst_n_i,
    input  logic bit_stb_i,
    input  logic inj_err_i,
    output logic tx_bit_o
);

    localparam int STATE_W = $bits(prbs_state_t);

    prbs_state_t lfsr_q;
    logic        fb;
    logic        armed_q;

    // Newest bit sits in lfsr_q[0]
    assign fb = lfsr_q[PRBS_TAP_A-1] ^ lfsr_q[PRBS_TAP_B-1];

    ////////////////////////////////////////
    // LFSR and error injection
    ////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q   <= PRBS_SEED;
            armed_q  <= 1'b0;
            tx_bit_o <= 1'b0;
        end else if (bit_stb_i) begin
            lfsr_q   <= {lfsr_q[STATE_W-2:0], fb};
            // Flag only flips the output and leaves the sequence untouched
            tx_bit_o <= fb ^ (armed_q | inj_err_i);
            armed_q  <= 1'b0;
        end else if (inj_err_i) begin
            armed_q <= 1'b1;
        end
    end

endmodule

// File: hdl/rx_checker.sv
`timescale 1ns/1ps

module rx_checker import link_emu_pkg::*; (
    input  logic     emu_clk,
    input  logic     arst_n_i,
    input  logic     bit_stb_i,
    input  logic     clear_i,
    input  sample_t  sample_i,
    output logic     rx_bit_o,
    output logic     locked_o,
    output err_cnt_t err_cnt_o
);

    localparam int HIST_W = $bits(prbs_state_t);

    prbs_state_t hist_q;
    logic [2:0]  fill_q;
    run_cnt_t    run_q;
    logic        rx_bit;
    logic        pred;
    logic        full;
    logic        miss;

    // Slicer
    assign rx_bit = (sample_i >= sample_t'(0));

    // Same recurrence as the generator
    assign pred = hist_q[PRBS_TAP_A-1] ^ hist_q[PRBS_TAP_B-1];
    assign full = (fill_q == 3'(HIST_W));
    assign miss = full && (pred != rx_bit);

    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_bit_o <= 1'b0;
        end else if (bit_stb_i) begin
            rx_bit_o <= rx_bit;
        end
    end

    ////////////////////////////////////////
    // History, lock and error count
    ////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q    <= '0;
            fill_q    <= '0;
            run_q     <= '0;
            locked_o  <= 1'b0;
            err_cnt_o <= '0;
        end else if (clear_i) begin
            hist_q    <= '0;
            fill_q    <= '0;
            run_q     <= '0;
            locked_o  <= 1'b0;
            err_cnt_o <= '0;
        end else if (bit_stb_i) begin
            hist_q <= {hist_q[HIST_W-2:0], rx_bit};
            if (!full) begin
                fill_q <= fill_q + 1'b1;
            end else if (miss) begin
                if (locked_o) begin
                    // Saturate at all ones
                    if (err_cnt_o != '1) begin
                        err_cnt_o <= err_cnt_o + 1'b1;
                    end
                end else begin
                    run_q <= '0;
                end
            end else if (!locked_o) begin
                run_q <= run_q + 1'b1;
                if (run_q == run_cnt_t'(LOCK_LEN - 1)) begin
                    locked_o <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/tx_driver.sv
`timescale 1ns/1ps

module tx_driver import link_emu_pkg::*; (
    input  logic    emu_clk,
    input  logic    arst_n_i,
    input  logic    bit_stb_i,
    input  logic    tx_bit_i,
    output sample_t level_o
);

    logic    prev_q;
    sample_t main_lvl;
    sample_t post_lvl;

    // Main cursor for the current bit
    assign main_lvl = tx_bit_i ? sample_t'(DRV_MAIN) : sample_t'(-DRV_MAIN);

    // De-emphasis from the previous bit
    assign post_lvl = prev_q ? sample_t'(DRV_POST) : sample_t'(-DRV_POST);

    always_ff @(posedge emu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_q  <= 1'b0;
            level_o <= '0;
        end else if (bit_stb_i) begin
            prev_q  <= tx_bit_i;
            level_o <= main_lvl - post_lvl;
        end
    end

endmodule

// File: verif/link_emu_tb.sv
`timescale 1ns/1ps

module link_emu_tb import link_emu_pkg::*; ();

    localparam int CLK_PER    = 8;
    localparam int HIST_LEN   = $bits(prbs_state_t);
    localparam int SPC_PAIRS  = 6;
    localparam int SPC_STB    = 8;
    localparam int DATA_STB   = 60;
    localparam int LOCK_STB   = 500;
    localparam int INJ_PULSES = 3;
    localparam int INJ_GAP    = 12;
    localparam int CLR_STB    = 60;
    localparam int MAX_PER    = 40;
    // Strobes of all tests at the longest bit period, plus margin
    localparam int BUDGET_STB = SPC_PAIRS * (SPC_STB + 2) + DATA_STB + LOCK_STB
                              + INJ_PULSES * INJ_GAP + CLR_STB;
    localparam int WATCHDOG_NS = (BUDGET_STB * MAX_PER + 500) * CLK_PER;

    logic      emu_clk;
    logic      arst_n_i;
    logic      en_i;
    half_per_t t_hi_i;
    half_per_t t_lo_i;
    logic      inj_err_i;
    logic      clear_i;
    logic      bit_stb_o;
    sample_t   sample_o;
    logic      rx_bit_o;
    logic      locked_o;
    err_cnt_t  err_cnt_o;

    int fail_cnt     = 0;
    int fail_at_test = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////

    int          cyc         = 0;
    int          next_stb    = -1;
    int          per         = 0;
    logic        prev_en     = 1'b0;
    logic        prev_locked = 1'b0;
    prbs_state_t ref_lfsr    = PRBS_SEED;
    logic        armed       = 1'b0;
    logic        m_tx        = 1'b0;
    logic        m_prev      = 1'b0;
    logic        m_rx        = 1'b0;
    logic        m_locked    = 1'b0;
    int          m_level     = 0;
    int          m_x1        = 0;
    int          m_x2        = 0;
    int          m_sample    = 0;
    prbs_state_t m_hist      = '0;
    int          fill        = 0;
    int          run         = 0;
    err_cnt_t    m_err       = '0;
    // Clean PRBS bits with bit 3 three strobes back
    logic [3:0]  clean       = '0;
    int          stb_n       = 0;
    int          rx_diff     = 0;
    int          since_clr   = 0;
    logic        clr_seen    = 1'b0;

    link_emu_top link_emu_top_i (
        .emu_clk   (emu_clk),
        .arst_n_i  (arst_n_i),
        .en_i      (en_i),
        .t_hi_i    (t_hi_i),
        .t_lo_i    (t_lo_i),
        .inj_err_i (inj_err_i),
        .clear_i   (clear_i),
        .bit_stb_o (bit_stb_o),
        .sample_o  (sample_o),
        .rx_bit_o  (rx_bit_o),
        .locked_o  (locked_o),
        .err_cnt_o (err_cnt_o)
    );

    task automatic report_mismatch(string sig, logic [31:0] exp_v, logic [31:0] act_v);
        $display("mismatch %s: expected %h, got %h at %0t ns", sig, exp_v, act_v, $time);
        fail_cnt++;
    endtask

    task automatic report_fail(string what);
        $display("%s at %0t ns", what, $time);
        fail_cnt++;
    endtask

    function automatic int eff_time(half_per_t t);
        return (t == '0) ? 1 : int'(t);
    endfunction

    // Pre-emphasis level from the current and previous bit
    function automatic int drive_level(logic cur, logic prev);
        return (cur ? DRV_MAIN : -DRV_MAIN) - (prev ? DRV_POST : -DRV_POST);
    endfunction

    function automatic int channel_out(int l0, int l1, int l2);
        int acc;
        acc = (CH_C0 * l0 + CH_C1 * l1 + CH_C2 * l2) >>> CH_SHIFT;
        if (acc > SAMPLE_MAX) begin
            acc = SAMPLE_MAX;
        end
        if (acc < SAMPLE_MIN) begin
            acc = SAMPLE_MIN;
        end
        return acc;
    endfunction

    task automatic wait_strobes(int n);
        repeat (n) begin
            @(posedge emu_clk);
            while (!bit_stb_o) begin
                @(posedge emu_clk);
            end
        end
        #1;
    endtask

    task automatic set_period(half_per_t hi, half_per_t lo);
        en_i = 1'b0;
        repeat (2) @(posedge emu_clk);
        #1;
        t_hi_i = hi;
        t_lo_i = lo;
        repeat (2) @(posedge emu_clk);
        #1;
        en_i = 1'b1;
    endtask

    task automatic send_clear();
        @(posedge emu_clk);
        #1;
        clear_i = 1'b1;
        @(posedge emu_clk);
        #1;
        clear_i = 1'b0;
    endtask

    task automatic send_inject();
        @(posedge emu_clk);
        #1;
        inj_err_i = 1'b1;
        @(posedge emu_clk);
        #1;
        inj_err_i = 1'b0;
    endtask

    task automatic end_test(int num, string name);
        tests_run++;
        if (fail_cnt != fail_at_test) begin
            tests_failed++;
            $display("test %0d %s: FAIL", num, name);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
        fail_at_test = fail_cnt;
    endtask

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PER / 2) emu_clk = ~emu_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // Monitor and reference model
    ////////////////////////////////////////

    always @(posedge emu_clk) begin
        logic fb;
        logic new_rx;
        int   new_sample;
        int   new_level;
        assert (bit_stb_o == (cyc == next_stb))
            else report_mismatch("bit_stb_o", cyc == next_stb, bit_stb_o);
        assert (sample_o == sample_t'(m_sample))
            else report_mismatch("sample_o", sample_t'(m_sample), sample_o);
        assert (rx_bit_o == m_rx) else report_mismatch("rx_bit_o", m_rx, rx_bit_o);
        assert (locked_o == m_locked) else report_mismatch("locked_o", m_locked, locked_o);
        assert (err_cnt_o == m_err) else report_mismatch("err_cnt_o", m_err, err_cnt_o);
        if (locked_o && !prev_locked && clr_seen) begin
            assert (since_clr == HIST_LEN + LOCK_LEN)
                else report_fail($sformatf("locked_o rose %0d strobes after clear, not %0d",
                                           since_clr, HIST_LEN + LOCK_LEN));
        end
        if (arst_n_i) begin
            // Bit clock timing
            if (bit_stb_o) begin
                next_stb = cyc + per;
            end
            if (en_i && !prev_en) begin
                next_stb = cyc + eff_time(t_lo_i) + 1;
                per      = eff_time(t_hi_i) + eff_time(t_lo_i);
            end else if (!en_i) begin
                next_stb = -1;
            end
            prev_en = en_i;
            // Source, driver, channel and slicer
            new_rx = m_rx;
            if (bit_stb_o) begin
                if (stb_n >= 3 && rx_bit_o != clean[3]) begin
                    rx_diff++;
                end
                new_rx     = (m_sample >= 0);
                new_sample = channel_out(m_level, m_x1, m_x2);
                new_level  = drive_level(m_tx, m_prev);
                m_x2       = m_x1;
                m_x1       = m_level;
                m_prev     = m_tx;
                fb         = ref_lfsr[PRBS_TAP_A-1] ^ ref_lfsr[PRBS_TAP_B-1];
                ref_lfsr   = {ref_lfsr[HIST_LEN-2:0], fb};
                m_tx       = fb ^ (armed | inj_err_i);
                armed      = 1'b0;
                clean      = {clean[2:0], fb};
                m_rx       = new_rx;
                m_sample   = new_sample;
                m_level    = new_level;
                stb_n++;
            end else if (inj_err_i) begin
                armed = 1'b1;
            end
            // Self-synchronizing checker
            if (clear_i) begin
                m_hist    = '0;
                fill      = 0;
                run       = 0;
                m_locked  = 1'b0;
                m_err     = '0;
                since_clr = 0;
                clr_seen  = 1'b1;
            end else if (bit_stb_o) begin
                since_clr++;
                if (fill < HIST_LEN) begin
                    fill++;
                end else if ((m_hist[PRBS_TAP_A-1] ^ m_hist[PRBS_TAP_B-1]) != new_rx) begin
                    if (m_locked) begin
                        if (m_err != '1) begin
                            m_err++;
                        end
                    end else begin
                        run = 0;
                    end
                end else if (!m_locked) begin
                    run++;
                    m_locked = (run == LOCK_LEN);
                end
                m_hist = {m_hist[HIST_LEN-2:0], new_rx};
            end
        end
        prev_locked = locked_o;
        cyc++;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        err_cnt_t err0;
        int       diff0;
        arst_n_i  = 1'b0;
        en_i      = 1'b0;
        t_hi_i    = 8'd2;
        t_lo_i    = 8'd3;
        inj_err_i = 1'b0;
        clear_i   = 1'b0;
        void'($urandom(38));
        repeat (10) @(posedge emu_clk);
        #1;
        arst_n_i = 1'b1;
        repeat (20) @(posedge emu_clk);
        #1;
        end_test(1, "reset state");

        for (int i = 0; i < SPC_PAIRS; i++) begin
            set_period(half_per_t'($urandom_range(20, 1)), half_per_t'($urandom_range(20, 1)));
            wait_strobes(SPC_STB);
        end
        end_test(2, "strobe spacing");

        set_period(8'd2, 8'd3);
        wait_strobes(DATA_STB);
        assert (rx_diff == 0) else report_mismatch("rx_bit_o bad bits", 0, rx_diff);
        end_test(3, "data path");

        send_clear();
        wait_strobes(LOCK_STB);
        assert (locked_o) else report_mismatch("locked_o", 1, locked_o);
        assert (err_cnt_o == '0) else report_mismatch("err_cnt_o", 0, err_cnt_o);
        end_test(4, "lock");

        // One bad bit is seen at the slicer and at both feedback taps
        for (int p = 0; p < INJ_PULSES; p++) begin
            err0  = err_cnt_o;
            diff0 = rx_diff;
            send_inject();
            wait_strobes(INJ_GAP);
            assert (err_cnt_o == err0 + 3) else report_mismatch("err_cnt_o", err0 + 3, err_cnt_o);
            assert (rx_diff == diff0 + 1)
                else report_mismatch("rx_bit_o bad bits", diff0 + 1, rx_diff);
        end
        end_test(5, "error injection");

        send_clear();
        assert (err_cnt_o == '0) else report_mismatch("err_cnt_o", 0, err_cnt_o);
        assert (!locked_o) else report_mismatch("locked_o", 0, locked_o);
        wait_strobes(CLR_STB);
        assert (locked_o) else report_mismatch("locked_o", 1, locked_o);
        assert (err_cnt_o == '0) else report_mismatch("err_cnt_o", 0, err_cnt_o);
        end_test(6, "clear");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, fail_cnt);
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/link_emu_pkg.sv
hdl/bit_clk_gen.sv
hdl/prbs_gen.sv
hdl/tx_driver.sv
hdl/chan_model.sv
hdl/rx_checker.sv
hdl/link_emu_top.sv
verif/link_emu_tb.sv
